//--- Makefile
VERILATOR  ?= verilator
TOP        := rs_decoder_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- design/codeword_streamer.sv
// Codeword to symbol serializer
`timescale 1ns/1ps

module codeword_streamer #(
    parameter int CODE_N = 76
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [CODE_N*rs_pkg::SYM_W-1:0]  received_code,
    symbol_stream_if.source                  stream
);

    logic [CODE_N*rs_pkg::SYM_W-1:0] code_q;
    rs_pkg::pos_t                    idx_q;
    logic                            full_q;
    logic                            accept;
    logic                            xfer;

    assign in_ready = !full_q;
    assign accept   = in_valid && in_ready;
    assign xfer     = stream.valid && stream.ready;

    assign stream.valid = full_q;
    assign stream.sym   = code_q[idx_q*rs_pkg::SYM_W +: rs_pkg::SYM_W]; // symbol 0 in low byte
    assign stream.last  = (idx_q == rs_pkg::POS_W'(CODE_N - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
            idx_q  <= '0;
        end else if (accept) begin
            full_q <= 1'b1;
            idx_q  <= '0;
        end else if (xfer) begin
            if (stream.last) begin
                full_q <= 1'b0;
                idx_q  <= '0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            code_q <= received_code;
        end
    end

endmodule

//--- design/rs_decoder_76_64.sv
// RS(76,64) decoder top
`timescale 1ns/1ps

module rs_decoder_76_64 (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          in_valid,
    output logic                                          in_ready,
    input  logic [rs_pkg::CODE_N*rs_pkg::SYM_W-1:0]       received_code,
    output logic                                          out_valid,
    input  logic                                          out_ready,
    output logic [rs_pkg::DATA_K*rs_pkg::SYM_W-1:0]       decoded_data,
    output rs_pkg::decode_status_t                        status,
    output rs_pkg::pos_t                                  error_position
);

    symbol_stream_if stream_if ();

    rs_pkg::syndrome_vec_t syndromes;

    codeword_streamer #(
        .CODE_N (rs_pkg::CODE_N)
    ) codeword_streamer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .received_code (received_code),
        .stream        (stream_if)
    );

    // one cell per root alpha^1 .. alpha^12
    for (genvar g = 0; g < rs_pkg::NUM_SYN; g++) begin : gen_syn
        syndrome_cell #(
            .ROOT_EXP (g + 1)
        ) syndrome_cell_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .stream   (stream_if),
            .syndrome (syndromes[g])
        );
    end

    single_error_corrector #(
        .CODE_N (rs_pkg::CODE_N)
    ) single_error_corrector_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .stream         (stream_if),
        .syndromes      (syndromes),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .decoded_data   (decoded_data),
        .status         (status),
        .error_position (error_position)
    );

endmodule

//--- design/rs_pkg.sv
// RS(76,64) shared definitions
package rs_pkg;

    localparam int SYM_W   = 8;
    localparam int CODE_N  = 76;
    localparam int DATA_K  = 64;
    localparam int NUM_SYN = 12;
    localparam int POS_W   = 7;

    localparam logic [SYM_W-1:0] GF_POLY_LOW = 8'h1D; // x^8+x^4+x^3+x^2+1
    localparam logic [SYM_W-1:0] ALPHA       = 8'h02;
    localparam logic [SYM_W-1:0] ALPHA_INV   = 8'h8E;

    typedef logic [SYM_W-1:0] sym_t;
    typedef logic [POS_W-1:0] pos_t;
    typedef sym_t [NUM_SYN-1:0] syndrome_vec_t; // entry i holds S_(i+1)

    typedef enum logic [1:0] {
        STATUS_CLEAN         = 2'd0,
        STATUS_CORRECTED     = 2'd1,
        STATUS_UNCORRECTABLE = 2'd2
    } decode_status_t;

    // carry-less product, then fold the top bits back down
    function automatic sym_t gf_mul(sym_t a, sym_t b);
        logic [2*SYM_W-2:0] prod;
        prod = '0;
        for (int i = 0; i < SYM_W; i++) begin
            if (b[i]) begin
                prod = prod ^ ({{(SYM_W-1){1'b0}}, a} << i);
            end
        end
        for (int i = 2*SYM_W-2; i >= SYM_W; i--) begin
            if (prod[i]) begin
                prod = prod ^ ({{(SYM_W-2){1'b0}}, 1'b1, GF_POLY_LOW} << (i - SYM_W));
            end
        end
        return prod[SYM_W-1:0];
    endfunction

    // constant powers only, the loop is unrolled at elaboration
    function automatic sym_t gf_pow_alpha(int power);
        sym_t result;
        result = 8'h01;
        for (int i = 0; i < (power % 255); i++) begin
            result = gf_mul(result, ALPHA);
        end
        return result;
    endfunction

    // x^254 = x^2 * x^4 * ... * x^128
    function automatic sym_t gf_inv(sym_t x);
        sym_t result;
        sym_t sq;
        result = 8'h01;
        sq     = x;
        for (int i = 1; i < SYM_W; i++) begin
            sq     = gf_mul(sq, sq);
            result = gf_mul(result, sq);
        end
        return result; // zero maps to zero
    endfunction

endpackage

//--- design/single_error_corrector.sv
// Single symbol error corrector
`timescale 1ns/1ps

module single_error_corrector #(
    parameter int CODE_N = 76
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    symbol_stream_if.sink                            stream,
    input  rs_pkg::syndrome_vec_t                    syndromes,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic [rs_pkg::DATA_K*rs_pkg::SYM_W-1:0]  decoded_data,
    output rs_pkg::decode_status_t                   status,
    output rs_pkg::pos_t                             error_position
);

    localparam rs_pkg::sym_t SCAN_START = rs_pkg::gf_pow_alpha(CODE_N - 1);
    localparam rs_pkg::pos_t LAST_IDX   = rs_pkg::POS_W'(CODE_N - 1);
    localparam rs_pkg::pos_t DATA_END   = rs_pkg::POS_W'(rs_pkg::DATA_K);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CLASSIFY,
        S_SCAN,
        S_DONE
    } state_t;

    state_t                  state_q;
    rs_pkg::pos_t            cap_idx_q;
    rs_pkg::pos_t            scan_idx_q;
    logic                    found_q;
    rs_pkg::decode_status_t  status_q;
    rs_pkg::pos_t            pos_q;

    logic [rs_pkg::DATA_K*rs_pkg::SYM_W-1:0] data_q;
    rs_pkg::sym_t            loc_q;       // X = alpha^degree of the error
    rs_pkg::sym_t            err_val_q;
    rs_pkg::sym_t            scan_val_q;

    logic                    xfer;
    logic                    hit;
    logic                    all_zero;
    logic                    chain_ok;
    rs_pkg::sym_t            s1;
    rs_pkg::sym_t            s2;
    rs_pkg::sym_t            loc;
    rs_pkg::sym_t            mag;

    assign stream.ready = (state_q == S_IDLE);
    assign xfer         = stream.valid && stream.ready;
    assign hit          = (state_q == S_SCAN) && (scan_val_q == loc_q);

    // single error e at degree j gives S_i = e * X^i with X = alpha^j
    always_comb begin
        s1       = syndromes[0];
        s2       = syndromes[1];
        all_zero = (syndromes == '0);
        loc      = rs_pkg::gf_mul(s2, rs_pkg::gf_inv(s1));
        mag      = rs_pkg::gf_mul(rs_pkg::gf_mul(s1, s1), rs_pkg::gf_inv(s2));
        chain_ok = (s1 != '0) && (s2 != '0);
        for (int i = 0; i < rs_pkg::NUM_SYN - 1; i++) begin
            if (syndromes[i+1] != rs_pkg::gf_mul(syndromes[i], loc)) begin
                chain_ok = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            cap_idx_q  <= '0;
            scan_idx_q <= '0;
            found_q    <= 1'b0;
            status_q   <= rs_pkg::STATUS_CLEAN;
            pos_q      <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (xfer) begin
                        cap_idx_q <= stream.last ? '0 : cap_idx_q + 1'b1;
                        if (stream.last) begin
                            state_q <= S_CLASSIFY;
                        end
                    end
                end
                S_CLASSIFY: begin
                    pos_q <= '0;
                    if (all_zero) begin
                        status_q <= rs_pkg::STATUS_CLEAN;
                        state_q  <= S_DONE;
                    end else if (chain_ok) begin
                        scan_idx_q <= '0;
                        found_q    <= 1'b0;
                        state_q    <= S_SCAN;
                    end else begin
                        status_q <= rs_pkg::STATUS_UNCORRECTABLE;
                        state_q  <= S_DONE;
                    end
                end
                S_SCAN: begin
                    if (hit) begin
                        found_q <= 1'b1;
                        pos_q   <= scan_idx_q;
                    end
                    // full scan every time, fixed latency
                    if (scan_idx_q == LAST_IDX) begin
                        state_q <= S_DONE;
                        if (found_q || hit) begin
                            status_q <= rs_pkg::STATUS_CORRECTED;
                        end else begin
                            status_q <= rs_pkg::STATUS_UNCORRECTABLE;
                            pos_q    <= '0;
                        end
                    end else begin
                        scan_idx_q <= scan_idx_q + 1'b1;
                    end
                end
                S_DONE: begin
                    if (out_ready) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && cap_idx_q < DATA_END) begin
            data_q[cap_idx_q*rs_pkg::SYM_W +: rs_pkg::SYM_W] <= stream.sym; // parity dropped
        end
        if (state_q == S_CLASSIFY) begin
            loc_q      <= loc;
            err_val_q  <= mag;
            scan_val_q <= SCAN_START;
        end
        if (state_q == S_SCAN) begin
            scan_val_q <= rs_pkg::gf_mul(scan_val_q, rs_pkg::ALPHA_INV);
        end
        if (hit && scan_idx_q < DATA_END) begin
            data_q[scan_idx_q*rs_pkg::SYM_W +: rs_pkg::SYM_W] <=
                data_q[scan_idx_q*rs_pkg::SYM_W +: rs_pkg::SYM_W] ^ err_val_q;
        end
    end

    assign out_valid      = (state_q == S_DONE);
    assign decoded_data   = data_q;
    assign status         = status_q;
    assign error_position = pos_q;

endmodule

//--- design/symbol_stream_if.sv
// Symbol stream interface
`timescale 1ns/1ps

interface symbol_stream_if;

    logic          valid;
    logic          ready;
    rs_pkg::sym_t  sym;
    logic          last;   // final symbol of a codeword

    modport source (output valid, output sym, output last, input ready);

    modport sink (input valid, input sym, input last, output ready);

    // syndrome cells only watch transfers
    modport monitor (input valid, input ready, input sym, input last);

endinterface

//--- design/syndrome_cell.sv
// Horner syndrome cell
`timescale 1ns/1ps

module syndrome_cell #(
    parameter int ROOT_EXP = 1
) (
    input  logic              clk,
    input  logic              rst_n,
    symbol_stream_if.monitor  stream,
    output rs_pkg::sym_t      syndrome
);

    localparam rs_pkg::sym_t ROOT = rs_pkg::gf_pow_alpha(ROOT_EXP);

    rs_pkg::sym_t acc_q;
    logic         first_q;  // next transfer opens a codeword

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q   <= '0;
            first_q <= 1'b1;
        end else if (stream.valid && stream.ready) begin
            // highest degree arrives first
            acc_q   <= (first_q ? '0 : rs_pkg::gf_mul(acc_q, ROOT)) ^ stream.sym;
            first_q <= stream.last;
        end
    end

    assign syndrome = acc_q;

endmodule

//--- filelist.f
+incdir+tests
design/rs_pkg.sv
design/symbol_stream_if.sv
design/codeword_streamer.sv
design/syndrome_cell.sv
design/single_error_corrector.sv
design/rs_decoder_76_64.sv
tests/rs_decoder_tb.sv

//--- tests/rs_tb_codec.svh
// RS reference encoder and stimulus helpers
`ifndef RS_TB_CODEC_SVH
`define RS_TB_CODEC_SVH

localparam int          NUM_PAR   = rs_pkg::CODE_N - rs_pkg::DATA_K;
localparam int          CODE_BITS = rs_pkg::CODE_N * rs_pkg::SYM_W;
localparam int          DATA_BITS = rs_pkg::DATA_K * rs_pkg::SYM_W;
localparam logic [31:0] LFSR_SEED = 32'h6d86ff0e;
localparam logic [31:0] LFSR_TAPS = 32'h80200003; // x^32+x^22+x^2+x+1
localparam logic [7:0]  PRIM      = 8'h02;

logic [31:0] lfsr_state;
logic [7:0]  gen_poly [NUM_PAR+1];   // index is the degree

// shift and add, reduce by 0x11D as we go
function automatic logic [7:0] field_mul(logic [7:0] a, logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] x;
    acc = 8'h00;
    x   = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            acc = acc ^ x;
        end
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1D : 8'h00);
    end
    return acc;
endfunction

function automatic logic lfsr_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? LFSR_TAPS : 32'h0);
    return out;
endfunction

function automatic logic [7:0] random_symbol();
    logic [7:0] s;
    for (int i = 0; i < 8; i++) begin
        s[i] = lfsr_bit(); // one step per bit
    end
    return s;
endfunction

function automatic logic [DATA_BITS-1:0] random_data();
    logic [DATA_BITS-1:0] d;
    for (int k = 0; k < rs_pkg::DATA_K; k++) begin
        d[k*8 +: 8] = random_symbol();
    end
    return d;
endfunction

// g(x) = (x + a^1)(x + a^2)...(x + a^12)
function automatic void build_generator();
    logic [7:0] root;
    for (int j = 0; j <= NUM_PAR; j++) begin
        gen_poly[j] = 8'h00;
    end
    gen_poly[0] = 8'h01;
    root        = 8'h01;
    for (int i = 1; i <= NUM_PAR; i++) begin
        root = field_mul(root, PRIM);
        for (int j = i; j > 0; j--) begin
            gen_poly[j] = gen_poly[j-1] ^ field_mul(gen_poly[j], root);
        end
        gen_poly[0] = field_mul(gen_poly[0], root);
    end
endfunction

// systematic, bus symbol 0 is the highest degree
function automatic logic [CODE_BITS-1:0] encode_codeword(logic [DATA_BITS-1:0] data);
    logic [7:0]           rem [NUM_PAR];
    logic [7:0]           fb;
    logic [CODE_BITS-1:0] cw;
    for (int j = 0; j < NUM_PAR; j++) begin
        rem[j] = 8'h00;
    end
    for (int k = 0; k < rs_pkg::DATA_K; k++) begin
        fb = data[k*8 +: 8] ^ rem[NUM_PAR-1];
        for (int j = NUM_PAR - 1; j > 0; j--) begin
            rem[j] = rem[j-1] ^ field_mul(fb, gen_poly[j]);
        end
        rem[0] = field_mul(fb, gen_poly[0]);
    end
    cw                = '0;
    cw[DATA_BITS-1:0] = data;
    for (int m = 0; m < NUM_PAR; m++) begin
        cw[(rs_pkg::DATA_K + m)*8 +: 8] = rem[NUM_PAR-1-m]; // degree 11 first
    end
    return cw;
endfunction

function automatic logic [CODE_BITS-1:0] inject_error(logic [CODE_BITS-1:0] cw, int idx,
                                                      logic [7:0] mag);
    cw[idx*8 +: 8] = cw[idx*8 +: 8] ^ mag;
    return cw;
endfunction

`endif

//--- tests/rs_decoder_tb.sv
// RS(76,64) decoder testbench
`timescale 1ns/1ps

module rs_decoder_tb;

    `include "rs_tb_codec.svh"

    localparam int NUM_CASES = 11;

    logic                          clk;
    logic                          rst_n;
    logic                          in_valid;
    logic                          in_ready;
    logic [CODE_BITS-1:0]          received_code;
    logic                          out_valid;
    logic                          out_ready;
    logic [DATA_BITS-1:0]          decoded_data;
    rs_pkg::decode_status_t        status;
    rs_pkg::pos_t                  error_position;

    // case table
    string                  case_name   [NUM_CASES];
    int                     case_pos_a  [NUM_CASES];
    logic [7:0]             case_mag_a  [NUM_CASES];  // zero means no error
    int                     case_pos_b  [NUM_CASES];
    logic [7:0]             case_mag_b  [NUM_CASES];
    int                     case_stall  [NUM_CASES];
    rs_pkg::decode_status_t case_status [NUM_CASES];
    int                     case_pos    [NUM_CASES];

    logic [CODE_BITS-1:0]   rx_code  [NUM_CASES];
    logic [DATA_BITS-1:0]   exp_data [NUM_CASES];
    int                     accepted_count;
    logic                   table_ready;

    rs_decoder_76_64 rs_decoder_76_64_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .received_code  (received_code),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .decoded_data   (decoded_data),
        .status         (status),
        .error_position (error_position)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic check_value(input string test, input string what,
                               input logic [DATA_BITS-1:0] expected,
                               input logic [DATA_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %0h, actual %0h", test, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic set_case(input int idx, input string name, input int pos_a,
                            input logic [7:0] mag_a, input int pos_b, input logic [7:0] mag_b,
                            input int stall, input rs_pkg::decode_status_t st, input int pos);
        case_name[idx]   = name;
        case_pos_a[idx]  = pos_a;
        case_mag_a[idx]  = mag_a;
        case_pos_b[idx]  = pos_b;
        case_mag_b[idx]  = mag_b;
        case_stall[idx]  = stall;
        case_status[idx] = st;
        case_pos[idx]    = pos;
    endtask

    task automatic prepare_cases();
        logic [DATA_BITS-1:0] data;
        logic [CODE_BITS-1:0] cw;
        set_case(0,  "clean",        0,  8'h00, 0,  8'h00, 0,  rs_pkg::STATUS_CLEAN, 0);
        set_case(1,  "data_0",       0,  8'h5A, 0,  8'h00, 0,  rs_pkg::STATUS_CORRECTED, 0);
        set_case(2,  "data_37",      37, 8'hC3, 0,  8'h00, 3,  rs_pkg::STATUS_CORRECTED, 37);
        set_case(3,  "data_63",      63, 8'h01, 0,  8'h00, 0,  rs_pkg::STATUS_CORRECTED, 63);
        set_case(4,  "parity_64",    64, 8'h7E, 0,  8'h00, 0,  rs_pkg::STATUS_CORRECTED, 64);
        set_case(5,  "parity_75",    75, 8'hFF, 0,  8'h00, 0,  rs_pkg::STATUS_CORRECTED, 75);
        set_case(6,  "double_data",  10, 8'h21, 50, 8'h9C, 0,  rs_pkg::STATUS_UNCORRECTABLE, 0);
        set_case(7,  "data_parity",  5,  8'h33, 70, 8'h44, 0,  rs_pkg::STATUS_UNCORRECTABLE, 0);
        set_case(8,  "stall_clean",  0,  8'h00, 0,  8'h00, 12, rs_pkg::STATUS_CLEAN, 0);
        set_case(9,  "stall_data",   20, 8'h66, 0,  8'h00, 20, rs_pkg::STATUS_CORRECTED, 20);
        set_case(10, "after_stall",  30, 8'h0F, 0,  8'h00, 0,  rs_pkg::STATUS_CORRECTED, 30);
        for (int c = 0; c < NUM_CASES; c++) begin
            data = random_data();
            cw   = encode_codeword(data);
            if (case_mag_a[c] != 8'h00) begin
                cw = inject_error(cw, case_pos_a[c], case_mag_a[c]);
            end
            if (case_mag_b[c] != 8'h00) begin
                cw = inject_error(cw, case_pos_b[c], case_mag_b[c]);
            end
            rx_code[c] = cw;
            // raw data passes through when nothing can be fixed
            if (case_status[c] == rs_pkg::STATUS_UNCORRECTABLE) begin
                exp_data[c] = cw[DATA_BITS-1:0];
            end else begin
                exp_data[c] = data;
            end
        end
    endtask

    task automatic send_codeword(input logic [CODE_BITS-1:0] cw);
        @(posedge clk);
        in_valid      <= 1'b1;
        received_code <= cw;
        do begin
            @(negedge clk);
        end while (!in_ready);
        @(posedge clk);   // transfer edge
        in_valid <= 1'b0;
        accepted_count = accepted_count + 1;
    endtask

    task automatic drive_all();
        for (int c = 0; c < NUM_CASES; c++) begin
            send_codeword(rx_code[c]);
        end
    endtask

    task automatic collect_all();
        logic [DATA_BITS-1:0]   held_data;
        rs_pkg::decode_status_t held_status;
        rs_pkg::pos_t           held_pos;
        for (int c = 0; c < NUM_CASES; c++) begin
            do begin
                @(negedge clk);
            end while (!out_valid);
            held_data   = decoded_data;
            held_status = status;
            held_pos    = error_position;
            repeat (case_stall[c]) begin
                @(negedge clk);
                check_value(case_name[c], "held valid", DATA_BITS'(1), DATA_BITS'(out_valid));
                check_value(case_name[c], "held data", held_data, decoded_data);
                check_value(case_name[c], "held status", DATA_BITS'(held_status),
                            DATA_BITS'(status));
                check_value(case_name[c], "held position", DATA_BITS'(held_pos),
                            DATA_BITS'(error_position));
            end
            // streamer took the next codeword during the stall
            if (case_stall[c] > 0 && c + 1 < NUM_CASES) begin
                check_value(case_name[c], "accepted count", DATA_BITS'(c + 2),
                            DATA_BITS'(accepted_count));
            end
            check_value(case_name[c], "status", DATA_BITS'(case_status[c]), DATA_BITS'(status));
            check_value(case_name[c], "position", DATA_BITS'(case_pos[c]),
                        DATA_BITS'(error_position));
            check_value(case_name[c], "data", exp_data[c], decoded_data);
            @(posedge clk);
            out_ready <= 1'b1;
            @(posedge clk);
            out_ready <= 1'b0;
        end
    endtask

    initial begin : main
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        out_ready      = 1'b0;
        received_code  = '0;
        accepted_count = 0;
        table_ready    = 1'b0;
        lfsr_state     = LFSR_SEED;
        build_generator();
        prepare_cases();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset", "in_ready", DATA_BITS'(1), DATA_BITS'(in_ready));
        check_value("reset", "out_valid", DATA_BITS'(0), DATA_BITS'(out_valid));
        fork
            drive_all();
            collect_all();
        join
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin : watchdog
        int max_stall;
        int budget;
        wait (table_ready);
        max_stall = 0;
        for (int c = 0; c < NUM_CASES; c++) begin
            if (case_stall[c] > max_stall) begin
                max_stall = case_stall[c];
            end
        end
        // worst case every codeword runs the full scan, one after another
        budget = 12 + NUM_CASES * (2 * rs_pkg::CODE_N + 16 + max_stall);
        repeat (budget) @(posedge clk);
        $display("ERROR: no result after %0d cycles, the decoder seems to be stuck", budget);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

endmodule
